/* src/attn_consts.svh */
// Attention engine sizes, matrix memory map and memory tag count
`ifndef ATTN_CONSTS_SVH
`define ATTN_CONSTS_SVH

// ------------------------------------------------------------
// Vector geometry
// ------------------------------------------------------------
`define MEM_BLOCKS_PER_VECTOR 2   // Memory blocks per vector
`define MEM_BLOCK_SIZE_BYTES  8   // Bytes per block
`define VECTOR_ELEMS          16  // Signed 8-bit elements per vector
`define MAX_SEQ_LENGTH        4   // Vectors per matrix

`define NUM_MEM_TAGS          15  // Loads the memory can hold in flight

// ------------------------------------------------------------
// Matrix base byte addresses
// ------------------------------------------------------------
`define K_BASE 16'h000
`define V_BASE 16'h100
`define Q_BASE 16'h200
`define O_BASE 16'h300  // Output rows written back here

`endif

/* src/attn_pkg.sv */
// Shared attention engine types: addresses, tags, memory blocks, commands and vectors
`include "attn_consts.svh"

package attn_pkg;

    typedef logic [15:0] addr_t;     // Byte address
    typedef logic [3:0]  mem_tag_t;  // 0 means no transaction

    // One memory block, whole or by byte
    typedef union packed {
        logic [`MEM_BLOCK_SIZE_BYTES-1:0][7:0] byte_level;
        logic [8*`MEM_BLOCK_SIZE_BYTES-1:0]    dword;
    } mem_block_t;

    // Memory command
    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_command_e;

    // ------------------------------------------------------------
    // Vector side
    // ------------------------------------------------------------
    typedef logic [`VECTOR_ELEMS-1:0][7:0] vector_t;  // 16 bytes, element e at byte e

    typedef logic [$clog2(`MAX_SEQ_LENGTH)-1:0] seq_idx_t;  // Row index in a matrix

endpackage

/* src/vector_store.sv */
// Vector store: one matrix of rows, filled over valid/ready and read by row index
`timescale 1ns/1ps
`include "attn_consts.svh"

module vector_store (
    input  logic               clk,
    input  logic               rst,
    input  logic               fill_vld,
    output logic               fill_rdy,
    input  attn_pkg::vector_t  fill_vector,
    output logic               full,
    input  attn_pkg::seq_idx_t rd_idx,
    output attn_pkg::vector_t  rd_vector
);
    import attn_pkg::*;

    vector_t  rows [`MAX_SEQ_LENGTH];  // Row storage
    seq_idx_t wr_ptr;                  // Next row slot
    logic     fill_fire;

    assign fill_rdy  = !full;                  // Accept until every slot is taken
    assign fill_fire = fill_vld && fill_rdy;
    assign rd_vector = rows[rd_idx];           // Combinational read for the core

    // Write pointer and full flag
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            full   <= 1'b0;
        end else if (fill_fire) begin
            wr_ptr <= wr_ptr + 1'b1;  // Wraps to 0 on the last row
            if (wr_ptr == seq_idx_t'(`MAX_SEQ_LENGTH - 1)) begin
                full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_fire) begin
            rows[wr_ptr] <= fill_vector;
        end
    end

endmodule

/* src/attn_core.sv */
// Attention core: scores each query against all keys and sums score-weighted value rows
`timescale 1ns/1ps
`include "attn_consts.svh"

module attn_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               q_full,
    output attn_pkg::seq_idx_t q_idx,
    output attn_pkg::seq_idx_t k_idx,
    output attn_pkg::seq_idx_t v_idx,
    input  attn_pkg::vector_t  q_vector,
    input  attn_pkg::vector_t  k_vector,
    input  attn_pkg::vector_t  v_vector,
    output logic               o_vld,
    input  logic               o_rdy,
    output attn_pkg::vector_t  o_vector
);
    import attn_pkg::*;

    localparam seq_idx_t LAST_IDX = seq_idx_t'(`MAX_SEQ_LENGTH - 1);

    typedef enum logic [2:0] {
        ST_IDLE,  // Waiting for the Q store to fill
        ST_RUN,   // One key per cycle
        ST_TAIL,  // Last multiply-accumulate
        ST_OUT,   // Finished row offered
        ST_STOP   // All rows written out
    } state_e;

    state_e     state;
    seq_idx_t   row;        // Query index i
    seq_idx_t   key;        // Key index j
    seq_idx_t   v_key;      // Key of the score in the pipeline register
    logic       mac_vld;    // score_q holds a live score
    logic [7:0] score;
    logic [7:0] score_q;
    vector_t    acc;        // Sixteen wrapping 8-bit accumulators
    logic       o_fire;

    assign q_idx    = row;
    assign k_idx    = key;
    assign v_idx    = v_key;    // V read one cycle behind K
    assign o_vld    = (state == ST_OUT);
    assign o_vector = acc;
    assign o_fire   = o_vld && o_rdy;

    // ------------------------------------------------------------
    // Score stage: Q[i] . K[j], low 8 bits only
    // ------------------------------------------------------------
    always_comb begin
        score = '0;
        for (int e = 0; e < `VECTOR_ELEMS; e++) begin
            score = score + q_vector[e] * k_vector[e];  // Wraps, sign irrelevant in low byte
        end
    end

    always_ff @(posedge clk) begin
        score_q <= score;
    end

    // ------------------------------------------------------------
    // Row and key walk
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            row     <= '0;
            key     <= '0;
            v_key   <= '0;
            mac_vld <= 1'b0;
        end else begin
            mac_vld <= (state == ST_RUN);
            case (state)
                ST_IDLE: if (q_full) state <= ST_RUN;  // K and V loaded before Q
                ST_RUN: begin
                    v_key <= key;
                    key   <= key + 1'b1;             // Back to 0 after the last key
                    if (key == LAST_IDX) state <= ST_TAIL;
                end
                ST_TAIL: state <= ST_OUT;
                ST_OUT: begin
                    if (o_rdy) begin
                        if (row == LAST_IDX) begin
                            state <= ST_STOP;
                        end else begin
                            row   <= row + 1'b1;
                            state <= ST_RUN;     // Next row right after handshake
                        end
                    end
                end
                default: state <= ST_STOP;
            endcase
        end
    end

    // Accumulate stage, cleared once the row is taken
    always_ff @(posedge clk) begin
        if (rst || o_fire) begin
            acc <= '0;
        end else if (mac_vld) begin
            for (int e = 0; e < `VECTOR_ELEMS; e++) begin
                acc[e] <= acc[e] + score_q * v_vector[e];
            end
        end
    end

endmodule

/* src/memory_controller.sv */
// Memory controller: streams K, V, Q rows in from tagged memory and writes output rows back
`timescale 1ns/1ps
`include "attn_consts.svh"

module memory_controller (
    input  logic                   clk,
    input  logic                   rst,
    input  attn_pkg::mem_tag_t     mem2proc_transaction_tag,
    input  attn_pkg::mem_block_t   mem2proc_data,
    input  attn_pkg::mem_tag_t     mem2proc_data_tag,
    output attn_pkg::mem_command_e proc2mem_command,
    output attn_pkg::addr_t        proc2mem_addr,
    output attn_pkg::mem_block_t   proc2mem_data,
    output logic                   k_vld,
    output logic                   v_vld,
    output logic                   q_vld,
    input  logic                   k_rdy,
    input  logic                   v_rdy,
    input  logic                   q_rdy,
    output attn_pkg::vector_t      loaded_vector,
    output logic                   o_rdy,
    input  logic                   o_vld,
    input  attn_pkg::vector_t      drained_vector,
    output logic                   done
);
    import attn_pkg::*;

    localparam int BLK_BYTES = `MEM_BLOCK_SIZE_BYTES;
    localparam int VEC_BYTES = `MEM_BLOCKS_PER_VECTOR * `MEM_BLOCK_SIZE_BYTES;
    localparam int BLK_W     = $clog2(`MEM_BLOCKS_PER_VECTOR);
    localparam int FIFO_W    = $clog2(`NUM_MEM_TAGS + 1);
    localparam seq_idx_t           LAST_VEC = seq_idx_t'(`MAX_SEQ_LENGTH - 1);
    localparam logic [BLK_W-1:0]   LAST_BLK = BLK_W'(`MEM_BLOCKS_PER_VECTOR - 1);
    localparam logic [BLK_W:0]     BLK_FULL = (BLK_W + 1)'(`MEM_BLOCKS_PER_VECTOR);

    typedef enum logic [2:0] {
        PH_RESET, PH_LOAD_K, PH_LOAD_V, PH_LOAD_Q, PH_DRAIN_O, PH_DONE
    } phase_e;

    phase_e            phase, phase_n;
    vector_t           vec_buf, vec_buf_n;        // Assembled or drained row
    seq_idx_t          vec_idx, vec_idx_n;        // Row handed over or stored
    logic [BLK_W:0]    blk_cnt, blk_cnt_n;        // Blocks held in vec_buf
    logic [BLK_W-1:0]  blk_pos, blk_pos_n;        // Next block slot of vec_buf
    seq_idx_t          fetch_vec, fetch_vec_n;    // Load issue position
    logic [BLK_W-1:0]  fetch_blk, fetch_blk_n;
    logic              fetch_done, fetch_done_n;  // Whole matrix issued
    mem_tag_t          tag_fifo [2**FIFO_W];      // Expected return tags in order
    logic [FIFO_W-1:0] tag_head, tag_head_n, tag_tail, tag_tail_n;
    logic              loading, buf_full, buf_empty, tags_empty, tags_full;
    logic              issue, ret, sel_rdy, fill_fire;
    addr_t             base;

    assign loading    = (phase == PH_LOAD_K) || (phase == PH_LOAD_V) || (phase == PH_LOAD_Q);
    assign buf_full   = (blk_cnt == BLK_FULL);
    assign buf_empty  = (blk_cnt == '0);
    assign tags_empty = (tag_head == tag_tail);
    assign tags_full  = (FIFO_W'(tag_tail + 1'b1) == tag_head);
    assign issue      = loading && !fetch_done && !tags_full;  // One load per cycle
    assign ret        = loading && !tags_empty && (mem2proc_data_tag == tag_fifo[tag_head]);
    assign fill_fire  = loading && buf_full && sel_rdy;

    // ------------------------------------------------------------
    // Store handshakes and status
    // ------------------------------------------------------------
    assign k_vld         = buf_full && (phase == PH_LOAD_K);
    assign v_vld         = buf_full && (phase == PH_LOAD_V);
    assign q_vld         = buf_full && (phase == PH_LOAD_Q);
    assign o_rdy         = buf_empty && (phase == PH_DRAIN_O);
    assign loaded_vector = vec_buf;
    assign done          = (phase == PH_DONE);

    always_comb begin
        case (phase)
            PH_LOAD_K: sel_rdy = k_rdy;
            PH_LOAD_V: sel_rdy = v_rdy;
            PH_LOAD_Q: sel_rdy = q_rdy;
            default:   sel_rdy = 1'b0;
        endcase
    end

    // Memory command, address and store data
    always_comb begin
        case (phase)
            PH_LOAD_K: base = `K_BASE;
            PH_LOAD_V: base = `V_BASE;
            PH_LOAD_Q: base = `Q_BASE;
            default:   base = `O_BASE;
        endcase
        if (loading) begin                  // Fetch side runs ahead of returns
            proc2mem_addr = base + addr_t'(int'(fetch_vec) * VEC_BYTES
                                           + int'(fetch_blk) * BLK_BYTES);
        end else begin
            proc2mem_addr = base + addr_t'(int'(vec_idx) * VEC_BYTES
                                           + int'(blk_pos) * BLK_BYTES);
        end
        if (issue)                                        proc2mem_command = MEM_LOAD;
        else if ((phase == PH_DRAIN_O) && !buf_empty)     proc2mem_command = MEM_STORE;
        else                                              proc2mem_command = MEM_NONE;
        proc2mem_data = '0;
        if (phase == PH_DRAIN_O) begin
            for (int b = 0; b < BLK_BYTES; b++) begin
                proc2mem_data.byte_level[b] = vec_buf[int'(blk_pos) * BLK_BYTES + b];
            end
        end
    end

    // ------------------------------------------------------------
    // Phase and buffer next state
    // ------------------------------------------------------------
    always_comb begin
        phase_n      = phase;
        vec_buf_n    = vec_buf;
        vec_idx_n    = vec_idx;
        blk_cnt_n    = blk_cnt;
        blk_pos_n    = blk_pos;
        fetch_vec_n  = fetch_vec;
        fetch_blk_n  = fetch_blk;
        fetch_done_n = fetch_done;
        tag_head_n   = tag_head;
        tag_tail_n   = tag_tail;
        if (phase == PH_RESET) phase_n = PH_LOAD_K;
        if (issue) begin
            tag_tail_n  = tag_tail + 1'b1;
            fetch_blk_n = fetch_blk + 1'b1;
            if (fetch_blk == LAST_BLK) begin
                fetch_vec_n = fetch_vec + 1'b1;
                if (fetch_vec == LAST_VEC) fetch_done_n = 1'b1;
            end
        end
        if (fill_fire) begin              // Row taken by its store
            blk_cnt_n = '0;
            vec_idx_n = vec_idx + 1'b1;
            if (vec_idx == LAST_VEC) begin
                fetch_done_n = 1'b0;
                phase_n = (phase == PH_LOAD_K) ? PH_LOAD_V :
                          (phase == PH_LOAD_V) ? PH_LOAD_Q : PH_DRAIN_O;
            end
        end
        if (ret) begin                    // Pack block into its slot
            for (int b = 0; b < BLK_BYTES; b++) begin
                vec_buf_n[int'(blk_pos) * BLK_BYTES + b] = mem2proc_data.byte_level[b];
            end
            blk_pos_n  = blk_pos + 1'b1;
            blk_cnt_n  = blk_cnt_n + 1'b1;
            tag_head_n = tag_head + 1'b1;
        end
        if (phase == PH_DRAIN_O) begin
            if (buf_empty && o_vld) begin
                vec_buf_n = drained_vector;
                blk_cnt_n = BLK_FULL;
            end else if (!buf_empty) begin  // Store issued this cycle
                blk_pos_n = blk_pos + 1'b1;
                blk_cnt_n = blk_cnt - 1'b1;
                if (blk_cnt == 1) begin
                    vec_idx_n = vec_idx + 1'b1;
                    if (vec_idx == LAST_VEC) phase_n = PH_DONE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) tag_fifo[tag_tail] <= mem2proc_transaction_tag;
        vec_buf <= vec_buf_n;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= PH_RESET;
            vec_idx    <= '0;
            blk_cnt    <= '0;
            blk_pos    <= '0;
            fetch_vec  <= '0;
            fetch_blk  <= '0;
            fetch_done <= 1'b0;
            tag_head   <= '0;
            tag_tail   <= '0;
        end else begin
            phase      <= phase_n;
            vec_idx    <= vec_idx_n;
            blk_cnt    <= blk_cnt_n;
            blk_pos    <= blk_pos_n;
            fetch_vec  <= fetch_vec_n;
            fetch_blk  <= fetch_blk_n;
            fetch_done <= fetch_done_n;
            tag_head   <= tag_head_n;
            tag_tail   <= tag_tail_n;
        end
    end

endmodule

/* src/attn_top.sv */
// Attention engine top: memory controller, K/V/Q vector stores and the attention core
`timescale 1ns/1ps

module attn_top (
    input  logic                   clk,
    input  logic                   rst,
    input  attn_pkg::mem_tag_t     mem2proc_transaction_tag,
    input  attn_pkg::mem_block_t   mem2proc_data,
    input  attn_pkg::mem_tag_t     mem2proc_data_tag,
    output attn_pkg::mem_command_e proc2mem_command,
    output attn_pkg::addr_t        proc2mem_addr,
    output attn_pkg::mem_block_t   proc2mem_data,
    output logic                   done
);
    import attn_pkg::*;

    logic     k_vld, v_vld, q_vld;       // Fill valids, one per store
    logic     k_rdy, v_rdy, q_rdy;
    vector_t  loaded_vector;             // Shared fill row
    logic     q_full;                    // Core start
    seq_idx_t q_idx, k_idx, v_idx;
    vector_t  q_vector, k_vector, v_vector;
    logic     o_vld, o_rdy;
    vector_t  o_vector;

    // ------------------------------------------------------------
    // Load and store path
    // ------------------------------------------------------------
    memory_controller i_mem_ctrl (
        .clk, .rst, .mem2proc_transaction_tag, .mem2proc_data, .mem2proc_data_tag,
        .proc2mem_command, .proc2mem_addr, .proc2mem_data,
        .k_vld, .v_vld, .q_vld, .k_rdy, .v_rdy, .q_rdy, .loaded_vector,
        .o_rdy, .o_vld, .drained_vector(o_vector), .done
    );

    // K and V full flags not needed, load order fills them before Q
    vector_store k_store (.clk, .rst, .fill_vld(k_vld), .fill_rdy(k_rdy),
        .fill_vector(loaded_vector), .full(), .rd_idx(k_idx), .rd_vector(k_vector));
    vector_store v_store (.clk, .rst, .fill_vld(v_vld), .fill_rdy(v_rdy),
        .fill_vector(loaded_vector), .full(), .rd_idx(v_idx), .rd_vector(v_vector));
    vector_store q_store (.clk, .rst, .fill_vld(q_vld), .fill_rdy(q_rdy),
        .fill_vector(loaded_vector), .full(q_full), .rd_idx(q_idx), .rd_vector(q_vector));

    // Compute
    attn_core i_core (
        .clk, .rst, .q_full, .q_idx, .k_idx, .v_idx,
        .q_vector, .k_vector, .v_vector, .o_vld, .o_rdy, .o_vector
    );

endmodule

/* testbench/tb_clk_gen.sv */
// Testbench clock and reset source: 8 ns clock, reset held for 4 rising edges
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;          // Released just after the 4th edge
    end

endmodule

/* testbench/tb_mem_model.sv */
// Tagged memory model: pattern image, in-order load returns with latency, store checking
`timescale 1ns/1ps
`include "attn_consts.svh"

module tb_mem_model (
    input  logic                   clk,
    input  attn_pkg::mem_command_e proc2mem_command,
    input  attn_pkg::addr_t        proc2mem_addr,
    input  attn_pkg::mem_block_t   proc2mem_data,
    output attn_pkg::mem_tag_t     mem2proc_transaction_tag,
    output attn_pkg::mem_block_t   mem2proc_data,
    output attn_pkg::mem_tag_t     mem2proc_data_tag,
    input  logic [`MAX_SEQ_LENGTH*`VECTOR_ELEMS-1:0][7:0] ref_o,  // Expected O region
    output logic                   store_err
);
    import attn_pkg::*;

    localparam int LOAD_LATENCY = 3;  // Base return delay in cycles
    localparam int BLK          = `MEM_BLOCK_SIZE_BYTES;
    localparam int O_BYTES      = `MAX_SEQ_LENGTH * `VECTOR_ELEMS;

    logic [7:0] image [1024];             // Byte image, covers all four matrices
    logic       written [O_BYTES / BLK];  // One flag per output block
    mem_tag_t   pend_tag [$];             // Loads in flight, oldest first
    mem_block_t pend_data [$];
    int         pend_due [$];             // Cycle each return is driven
    mem_tag_t   next_tag;
    integer     seed;
    int         cycle;

    function automatic mem_block_t read_block(input addr_t a);
        mem_block_t blk;
        for (int k = 0; k < BLK; k++) begin
            blk.byte_level[k] = image[10'(int'(a) + k)];  // Byte k sits at a + k
        end
        return blk;
    endfunction

    // ------------------------------------------------------------
    // Store check against the reference rows
    // ------------------------------------------------------------
    task automatic check_store();
        int         off;
        mem_block_t exp_blk;
        off = int'(proc2mem_addr) - `O_BASE;
        if (off < 0 || off > O_BYTES - BLK) begin
            $display("store to address %h falls outside the output region", proc2mem_addr);
            store_err = 1'b1;
        end else begin
            for (int k = 0; k < BLK; k++) begin
                exp_blk.byte_level[k] = ref_o[off + k];
            end
            assert (proc2mem_data == exp_blk) else begin
                $display("mismatch at %0t ns: O store to %h, expected %h, got %h",
                         $time, proc2mem_addr, exp_blk, proc2mem_data);
                store_err = 1'b1;
            end
            assert (!written[off / BLK]) else begin
                $display("output block at %h was written twice", proc2mem_addr);
                store_err = 1'b1;
            end
            written[off / BLK] = 1'b1;
            for (int k = 0; k < BLK; k++) begin
                image[10'(int'(proc2mem_addr) + k)] = proc2mem_data.byte_level[k];
            end
        end
    endtask

    initial begin
        int extra;
        int due;
        seed      = 32'h8384f45f;
        next_tag  = 4'd1;
        cycle     = 0;
        store_err = 1'b0;
        mem2proc_transaction_tag = '0;
        mem2proc_data            = '0;
        mem2proc_data_tag        = '0;
        // Low byte of addr*7+3 folded with the upper address bits so K, V and Q differ
        for (int a = 0; a < 1024; a++) begin
            image[a] = 8'(a * 7 + 3) ^ 8'(a >> 8);
        end
        for (int b = 0; b < O_BYTES / BLK; b++) begin
            written[b] = 1'b0;
        end
        forever begin
            @(posedge clk);
            #1;                                   // Command settled so drive this cycle
            cycle                    = cycle + 1;
            mem2proc_transaction_tag = '0;
            mem2proc_data_tag        = '0;
            mem2proc_data            = '0;        // Data only alongside a tag
            if (proc2mem_command == MEM_LOAD) begin
                extra = $random(seed) & 1;         // Sometimes one cycle late
                due   = cycle + LOAD_LATENCY + extra;
                if (pend_due.size() > 0 && due <= pend_due[$]) begin
                    due = pend_due[$] + 1;         // Keep returns in order
                end
                pend_tag.push_back(next_tag);
                pend_data.push_back(read_block(proc2mem_addr));
                pend_due.push_back(due);
                mem2proc_transaction_tag = next_tag;
                next_tag = (next_tag == mem_tag_t'(`NUM_MEM_TAGS)) ? 4'd1 : next_tag + 1'b1;
            end else if (proc2mem_command == MEM_STORE) begin
                check_store();
            end
            if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
                mem2proc_data_tag = pend_tag.pop_front();
                mem2proc_data     = pend_data.pop_front();
                void'(pend_due.pop_front());
            end
        end
    end

endmodule

/* testbench/attn_chk.sv */
// Protocol checker for the attention engine memory port: reset, address order, tags, done
`timescale 1ns/1ps
`include "attn_consts.svh"

module attn_chk (
    input  logic                   clk,
    input  logic                   rst,
    input  attn_pkg::mem_command_e proc2mem_command,
    input  attn_pkg::addr_t        proc2mem_addr,
    input  attn_pkg::mem_tag_t     mem2proc_data_tag,
    input  logic                   done
);
    import attn_pkg::*;

    localparam int MAT_BYTES = `MAX_SEQ_LENGTH * `VECTOR_ELEMS;  // Bytes used per matrix

    int         fail_cnt = 0;   // Failed assertions counted for tb_top
    logic [1:0] load_region;    // Latest matrix loaded as 0 K, 1 V or 2 Q
    logic [4:0] in_flight;      // Loads issued and not yet returned
    logic       is_load;
    logic       is_store;

    assign is_load  = (proc2mem_command == MEM_LOAD);
    assign is_store = (proc2mem_command == MEM_STORE);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_region <= 2'd0;
            in_flight   <= '0;
        end else begin
            if (is_load) load_region <= proc2mem_addr[9:8];  // Regions 0x100 apart
            in_flight <= in_flight + 5'(is_load) - 5'(mem2proc_data_tag != '0);
        end
    end

    // ------------------------------------------------------------
    // Reset and address rules
    // ------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (proc2mem_command == MEM_NONE) && !done)
        else begin
            fail_cnt++;
            $error("memory command or done active around reset");
        end

    a_load_range: assert property (@(posedge clk) disable iff (rst)
        is_load |-> (proc2mem_addr < `O_BASE) && (proc2mem_addr[7:0] < MAT_BYTES))
        else begin
            fail_cnt++;
            $error("load address outside the K, V and Q rows");
        end

    a_store_range: assert property (@(posedge clk) disable iff (rst)
        is_store |-> (proc2mem_addr >= `O_BASE) && (proc2mem_addr < `O_BASE + MAT_BYTES))
        else begin
            fail_cnt++;
            $error("store address outside the output rows");
        end

    a_load_order: assert property (@(posedge clk) disable iff (rst)
        is_load |-> (proc2mem_addr[9:8] >= load_region))
        else begin
            fail_cnt++;
            $error("load went back to an earlier matrix");
        end

    a_store_after_q: assert property (@(posedge clk) disable iff (rst)
        is_store |-> (load_region == 2'd2))
        else begin
            fail_cnt++;
            $error("store issued before the Q matrix was loaded");
        end

    // Tags and completion
    a_tag_limit: assert property (@(posedge clk) disable iff (rst)
        in_flight <= 5'(`NUM_MEM_TAGS))
        else begin
            fail_cnt++;
            $error("more loads outstanding than memory tags");
        end

    a_done_holds: assert property (@(posedge clk) disable iff (rst)
        done |=> done)
        else begin
            fail_cnt++;
            $error("done dropped after it was raised");
        end

    a_done_after_store: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(is_store))
        else begin
            fail_cnt++;
            $error("done did not follow the last store");
        end

endmodule

/* testbench/tb_top.sv */
// Testbench top: attention engine with memory model, reference rows, watchdog and verdict
`timescale 1ns/1ps
`include "attn_consts.svh"

module tb_top;
    import attn_pkg::*;

    localparam int ELEMS    = `VECTOR_ELEMS;
    localparam int VEC_B    = `MEM_BLOCKS_PER_VECTOR * `MEM_BLOCK_SIZE_BYTES;
    localparam int O_BLOCKS = `MAX_SEQ_LENGTH * `MEM_BLOCKS_PER_VECTOR;
    localparam int WATCHDOG_NS = 8 * (3 * `MAX_SEQ_LENGTH * `MEM_BLOCKS_PER_VECTOR * 5
                                      + `MAX_SEQ_LENGTH * (`MAX_SEQ_LENGTH + 4) + 100);

    logic         clk;
    logic         rst;
    mem_tag_t     mem2proc_transaction_tag;
    mem_block_t   mem2proc_data;
    mem_tag_t     mem2proc_data_tag;
    mem_command_e proc2mem_command;
    addr_t        proc2mem_addr;
    mem_block_t   proc2mem_data;
    logic         done;
    logic [`MAX_SEQ_LENGTH*ELEMS-1:0][7:0] ref_o;  // Expected output rows with a byte per element
    logic         store_err;
    int           store_cnt = 0;
    int           chk_fails;
    logic         failed;

    tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

    attn_top i_dut (
        .clk, .rst, .mem2proc_transaction_tag, .mem2proc_data, .mem2proc_data_tag,
        .proc2mem_command, .proc2mem_addr, .proc2mem_data, .done
    );

    tb_mem_model i_mem (
        .clk, .proc2mem_command, .proc2mem_addr, .proc2mem_data,
        .mem2proc_transaction_tag, .mem2proc_data, .mem2proc_data_tag,
        .ref_o, .store_err
    );

    bind attn_top attn_chk i_chk (
        .clk(clk), .rst(rst), .proc2mem_command(proc2mem_command),
        .proc2mem_addr(proc2mem_addr), .mem2proc_data_tag(mem2proc_data_tag), .done(done)
    );

    assign chk_fails = i_dut.i_chk.fail_cnt;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic logic [7:0] pattern_byte(input int a);
        return 8'(a * 7 + 3) ^ 8'(a >> 8);  // Same image the memory starts with
    endfunction

    // O[i][e] = sum_j (Q[i].K[j] mod 256) * V[j][e], mod 256
    task automatic build_reference();
        int score;
        int sum;
        for (int i = 0; i < `MAX_SEQ_LENGTH; i++) begin
            for (int e = 0; e < ELEMS; e++) begin
                sum = 0;
                for (int j = 0; j < `MAX_SEQ_LENGTH; j++) begin
                    score = 0;
                    for (int x = 0; x < ELEMS; x++) begin
                        score += int'(pattern_byte(`Q_BASE + i * VEC_B + x))
                               * int'(pattern_byte(`K_BASE + j * VEC_B + x));
                    end
                    sum += (score & 255) * int'(pattern_byte(`V_BASE + j * VEC_B + e));
                end
                ref_o[i * ELEMS + e] = 8'(sum);
            end
        end
    endtask

    // Stores seen on the bus sampled away from the clock edge
    always @(negedge clk) begin
        if (!rst && proc2mem_command == MEM_STORE) store_cnt++;
    end

    initial begin
        wait (store_err || chk_fails != 0);
        $display("Some tests failed");
        $fatal(1, "a memory or protocol check failed");
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns without done", WATCHDOG_NS);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        failed = 1'b0;
        build_reference();
        wait (!rst);
        wait (done);
        repeat (4) @(posedge clk);  // Let the checker see done hold
        @(negedge clk);
        assert (store_cnt == O_BLOCKS) else begin
            $display("mismatch at %0t ns: expected %0d output block stores, saw %0d",
                     $time, O_BLOCKS, store_cnt);
            failed = 1'b1;
        end
        if (failed || store_err || chk_fails != 0) begin
            $display("Some tests failed");
            $fatal(1, "end of run checks failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+src
src/attn_pkg.sv
src/vector_store.sv
src/attn_core.sv
src/memory_controller.sv
src/attn_top.sv
testbench/tb_clk_gen.sv
testbench/tb_mem_model.sv
testbench/attn_chk.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the attention engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f verilog.f -o Vtb_top

./obj_dir/Vtb_top +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "FAIL: see sim.log"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "FAIL: simulation ended without a verdict"
    exit 1
fi
echo "PASS"
